//--- ahb_endpoint_slave.f
logic/ahb_pkg.sv
logic/endpoint_pkg.sv
logic/slave_access_if.sv
logic/ahb_lite_front.sv
logic/endpoint_regs.sv
logic/buffer_port.sv
logic/ahb_endpoint_slave.sv
test/tb_clock_gen.sv
test/ahb_endpoint_slave_checker.sv
test/tb_ahb_endpoint_slave.sv

//--- logic/ahb_endpoint_slave.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_endpoint_slave (
  input  wire                      tb_clk,
  input  wire                      arst_n_i,
  // AHB-Lite slave side
  input  wire                      hsel_i,
  input  ahb_pkg::addr_t           haddr_i,
  input  ahb_pkg::hsize_t          hsize_i,
  input  ahb_pkg::htrans_t         htrans_i,
  input  wire                      hwrite_i,
  input  ahb_pkg::data_t           hwdata_i,
  output ahb_pkg::data_t           hrdata_o,
  output logic                     hresp_o,
  output logic                     hready_o,
  // Endpoint status and receive data
  input  wire                      rx_data_ready_i,
  input  wire                      rx_transfer_active_i,
  input  wire                      rx_error_i,
  input  wire                      tx_transfer_active_i,
  input  wire                      tx_error_i,
  input  endpoint_pkg::occ_t       buffer_occupancy_i,
  input  ahb_pkg::data_t           rx_data_i,
  // Endpoint control and transmit data
  output logic                     buffer_reserved_o,
  output endpoint_pkg::tx_size_t   tx_packet_data_size_o,
  output logic                     get_rx_data_o,
  output logic                     store_tx_data_o,
  output ahb_pkg::data_t           tx_data_o,
  output ahb_pkg::hsize_t          data_size_o
);

  // Read data back to the front end
  ahb_pkg::data_t regs_rdata;
  ahb_pkg::data_t buf_rdata;

  // Decoded access links
  slave_access_if acc_regs ();
  slave_access_if acc_buf ();

  // ****************************************
  // Bus front end
  // ****************************************
  ahb_lite_front u_front (
    .tb_clk       (tb_clk),
    .arst_n_i     (arst_n_i),
    .hsel_i       (hsel_i),
    .haddr_i      (haddr_i),
    .hsize_i      (hsize_i),
    .htrans_i     (htrans_i),
    .hwrite_i     (hwrite_i),
    .hwdata_i     (hwdata_i),
    .hrdata_o     (hrdata_o),
    .hresp_o      (hresp_o),
    .hready_o     (hready_o),
    .regs_rdata_i (regs_rdata),
    .buf_rdata_i  (buf_rdata),
    .acc_regs     (acc_regs.initiator),
    .acc_buf      (acc_buf.initiator)
  );

  // Status, occupancy and size register
  endpoint_regs u_regs (
    .tb_clk                (tb_clk),
    .arst_n_i              (arst_n_i),
    .rx_data_ready_i       (rx_data_ready_i),
    .rx_transfer_active_i  (rx_transfer_active_i),
    .rx_error_i            (rx_error_i),
    .tx_transfer_active_i  (tx_transfer_active_i),
    .tx_error_i            (tx_error_i),
    .buffer_occupancy_i    (buffer_occupancy_i),
    .rdata_o               (regs_rdata),
    .buffer_reserved_o     (buffer_reserved_o),
    .tx_packet_data_size_o (tx_packet_data_size_o),
    .acc                   (acc_regs.target)
  );

  // Data buffer window
  buffer_port u_buf (
    .tb_clk          (tb_clk),
    .arst_n_i        (arst_n_i),
    .rx_data_i       (rx_data_i),
    .rdata_o         (buf_rdata),
    .get_rx_data_o   (get_rx_data_o),
    .store_tx_data_o (store_tx_data_o),
    .tx_data_o       (tx_data_o),
    .data_size_o     (data_size_o),
    .acc             (acc_buf.target)
  );

endmodule

`default_nettype wire

//--- logic/ahb_lite_front.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_lite_front (
  input  wire                  tb_clk,
  input  wire                  arst_n_i,
  // AHB-Lite slave side
  input  wire                  hsel_i,
  input  ahb_pkg::addr_t       haddr_i,
  input  ahb_pkg::hsize_t      hsize_i,
  input  ahb_pkg::htrans_t     htrans_i,
  input  wire                  hwrite_i,
  input  ahb_pkg::data_t       hwdata_i,
  output ahb_pkg::data_t       hrdata_o,
  output logic                 hresp_o,
  output logic                 hready_o,
  // Read data back from targets
  input  ahb_pkg::data_t       regs_rdata_i,
  input  ahb_pkg::data_t       buf_rdata_i,
  // Decoded accesses
  slave_access_if.initiator    acc_regs,
  slave_access_if.initiator    acc_buf
);
  import ahb_pkg::*;
  import endpoint_pkg::*;

  // Error response sequencer
  typedef enum logic [1:0] {
    ST_OK   = 2'd0,
    ST_ERR1 = 2'd1,
    ST_ERR2 = 2'd2
  } err_state_t;

  err_state_t state_q;
  err_state_t state_d;

  logic    accept;
  logic    illegal;
  region_t region;

  // Data phase copies of the address phase
  logic    dp_valid_q;
  logic    dp_write_q;
  hsize_t  dp_size_q;
  region_t dp_region_q;

  // ****************************************
  // Address phase
  // ****************************************
  // Transfer taken only when selected, active and not stalled
  assign accept = hsel_i && (htrans_i == NONSEQ || htrans_i == SEQ) && hready_o;

  // Address decode
  always_comb begin
    if (haddr_i <= BUFFER_TOP) begin
      region = BUFFER;
    end else if (haddr_i[ADDR_W-1:2] == STATUS_ADDR[ADDR_W-1:2]) begin
      region = STATUS;
    end else if (haddr_i[ADDR_W-1:1] == OCC_ADDR[ADDR_W-1:1]) begin
      region = OCCUPANCY;
    end else if (haddr_i == TX_SIZE_ADDR) begin
      region = TX_SIZE;
    end else begin
      // 0x46, 0x47 and 0x49 upward
      region = NONE;
    end
  end

  // Unallocated, read-only written, or wider than a word
  assign illegal = (region == NONE)
                || (hwrite_i && (region == STATUS || region == OCCUPANCY))
                || (hsize_i == DWORD);

  // Capture for the data phase
  always_ff @(posedge tb_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dp_valid_q  <= 1'b0;
      dp_write_q  <= 1'b0;
      dp_size_q   <= BYTE;
      dp_region_q <= NONE;
    end else begin
      dp_valid_q <= accept && !illegal;
      if (accept) begin
        dp_write_q  <= hwrite_i;
        dp_size_q   <= hsize_i;
        dp_region_q <= region;
      end
    end
  end

  // ****************************************
  // Error response FSM
  // ****************************************
  always_comb begin
    state_d = ST_OK;
    case (state_q)
      // First error cycle always runs into the second
      ST_ERR1: state_d = ST_ERR2;
      default: begin
        if (accept && illegal) begin
          state_d = ST_ERR1;
        end
      end
    endcase
  end

  always_ff @(posedge tb_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_OK;
    end else begin
      state_q <= state_d;
    end
  end

  // Stall only in the first error cycle
  assign hready_o = (state_q != ST_ERR1);
  assign hresp_o  = (state_q != ST_OK);

  // ****************************************
  // Data phase
  // ****************************************
  // Exactly one target sees valid
  assign acc_buf.valid   = dp_valid_q && (dp_region_q == BUFFER);
  assign acc_buf.write   = dp_write_q;
  assign acc_buf.size    = dp_size_q;
  assign acc_buf.region  = dp_region_q;
  assign acc_buf.wdata   = hwdata_i;

  assign acc_regs.valid  = dp_valid_q && (dp_region_q != BUFFER);
  assign acc_regs.write  = dp_write_q;
  assign acc_regs.size   = dp_size_q;
  assign acc_regs.region = dp_region_q;
  assign acc_regs.wdata  = hwdata_i;

  // Read data steering, zero outside a good read
  always_comb begin
    hrdata_o = '0;
    if (dp_valid_q && !dp_write_q) begin
      if (dp_region_q == BUFFER) begin
        hrdata_o = buf_rdata_i;
      end else begin
        hrdata_o = regs_rdata_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/ahb_pkg.sv
`default_nettype none

package ahb_pkg;

  // ****************************************
  // Bus widths
  // ****************************************
  localparam int unsigned ADDR_W = 7;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // ****************************************
  // Transfer and size codes
  // ****************************************
  // HTRANS encoding per AHB-Lite
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // Low two bits of HSIZE, doubleword is beyond this slave
  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HALF  = 2'b01,
    WORD  = 2'b10,
    DWORD = 2'b11
  } hsize_t;

  // Keeps the byte lanes covered by an access of the given size
  function automatic data_t lane_mask(hsize_t size);
    case (size)
      BYTE:    return data_t'(8'hFF);
      HALF:    return data_t'(16'hFFFF);
      default: return '1;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- logic/buffer_port.sv
`timescale 1ns/1ns
`default_nettype none

module buffer_port (
  input  wire               tb_clk,
  input  wire               arst_n_i,
  // Head word of the external buffer
  input  ahb_pkg::data_t    rx_data_i,
  output ahb_pkg::data_t    rdata_o,
  // Strobes toward the buffer
  output logic              get_rx_data_o,
  output logic              store_tx_data_o,
  output ahb_pkg::data_t    tx_data_o,
  output ahb_pkg::hsize_t   data_size_o,
  slave_access_if.target    acc
);
  import ahb_pkg::*;

  logic   store_q;
  data_t  tx_data_q;
  hsize_t data_size_q;
  data_t  mask;

  // Lanes kept for this access size
  assign mask = lane_mask(acc.size);

  // ****************************************
  // Transmit path
  // ****************************************
  // Strobe in the cycle after the write data phase
  always_ff @(posedge tb_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      store_q <= 1'b0;
    end else begin
      store_q <= acc.valid && acc.write;
    end
  end

  // Payload held only while a write lands
  always_ff @(posedge tb_clk) begin
    if (acc.valid && acc.write) begin
      tx_data_q   <= acc.wdata & mask;
      data_size_q <= acc.size;
    end
  end

  assign store_tx_data_o = store_q;
  assign tx_data_o       = tx_data_q;
  assign data_size_o     = data_size_q;

  // ****************************************
  // Receive path
  // ****************************************
  // Pop during the read data phase, FWFT head already present
  assign get_rx_data_o = acc.valid && !acc.write;
  assign rdata_o       = rx_data_i & mask;

endmodule

`default_nettype wire

//--- logic/endpoint_pkg.sv
`default_nettype none

package endpoint_pkg;

  // ****************************************
  // Address map
  // ****************************************
  // Data buffer window spans 0x00 up to here
  localparam ahb_pkg::addr_t BUFFER_TOP   = 7'h3F;
  // Read-only status word, 0x40 to 0x43
  localparam ahb_pkg::addr_t STATUS_ADDR  = 7'h40;
  // Read-only occupancy, 0x44 to 0x45
  localparam ahb_pkg::addr_t OCC_ADDR     = 7'h44;
  // Writable endpoint-to-host transfer size
  localparam ahb_pkg::addr_t TX_SIZE_ADDR = 7'h48;

  // Decoded target of one access
  typedef enum logic [2:0] {
    BUFFER    = 3'd0,
    STATUS    = 3'd1,
    OCCUPANCY = 3'd2,
    TX_SIZE   = 3'd3,
    NONE      = 3'd4
  } region_t;

  // ****************************************
  // Status word bit positions
  // ****************************************
  localparam int unsigned ST_RX_READY  = 0;
  localparam int unsigned ST_RX_ACTIVE = 1;
  localparam int unsigned ST_TX_ACTIVE = 2;
  localparam int unsigned ST_RX_ERROR  = 8;
  localparam int unsigned ST_TX_ERROR  = 9;

  // Register payloads
  typedef logic [6:0] tx_size_t;
  typedef logic [6:0] occ_t;

endpackage

`default_nettype wire

//--- logic/endpoint_regs.sv
`timescale 1ns/1ns
`default_nettype none

module endpoint_regs (
  input  wire                      tb_clk,
  input  wire                      arst_n_i,
  // Endpoint status
  input  wire                      rx_data_ready_i,
  input  wire                      rx_transfer_active_i,
  input  wire                      rx_error_i,
  input  wire                      tx_transfer_active_i,
  input  wire                      tx_error_i,
  input  endpoint_pkg::occ_t       buffer_occupancy_i,
  // Register side
  output ahb_pkg::data_t           rdata_o,
  output logic                     buffer_reserved_o,
  output endpoint_pkg::tx_size_t   tx_packet_data_size_o,
  slave_access_if.target           acc
);
  import ahb_pkg::*;
  import endpoint_pkg::*;

  tx_size_t tx_size_q;
  // Sampled and delayed copies of tx activity
  logic     tx_active_s_q;
  logic     tx_active_d_q;
  logic     tx_done;
  data_t    status_word;

  // ****************************************
  // Transfer size register
  // ****************************************
  // Falling edge, one cycle after sampling
  assign tx_done = tx_active_d_q && !tx_active_s_q;

  always_ff @(posedge tb_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_active_s_q <= 1'b0;
      tx_active_d_q <= 1'b0;
    end else begin
      tx_active_s_q <= tx_transfer_active_i;
      tx_active_d_q <= tx_active_s_q;
    end
  end

  always_ff @(posedge tb_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_size_q <= '0;
    end else if (acc.valid && acc.write) begin
      // Only the size register is writable here
      // A new size wins over a clear in the same cycle
      tx_size_q <= acc.wdata[6:0];
    end else if (tx_done) begin
      tx_size_q <= '0;
    end
  end

  assign tx_packet_data_size_o = tx_size_q;
  // Buffer held for the host while a size is pending
  assign buffer_reserved_o     = (tx_size_q != '0);

  // ****************************************
  // Read mux
  // ****************************************
  // Live status, not registered
  always_comb begin
    status_word               = '0;
    status_word[ST_RX_READY]  = rx_data_ready_i;
    status_word[ST_RX_ACTIVE] = rx_transfer_active_i;
    status_word[ST_TX_ACTIVE] = tx_transfer_active_i;
    status_word[ST_RX_ERROR]  = rx_error_i;
    status_word[ST_TX_ERROR]  = tx_error_i;
  end

  always_comb begin
    case (acc.region)
      STATUS:    rdata_o = status_word;
      OCCUPANCY: rdata_o = data_t'(buffer_occupancy_i);
      TX_SIZE:   rdata_o = data_t'(tx_size_q);
      default:   rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/slave_access_if.sv
`timescale 1ns/1ns
`default_nettype none

// One decoded data-phase access, front end to a target
interface slave_access_if;
  import ahb_pkg::*;
  import endpoint_pkg::*;

  // High for the single cycle of a good data phase
  logic    valid;
  logic    write;
  hsize_t  size;
  // Sideband, latched at address phase
  region_t region;
  // Live bus write data, sampled by target at end of data phase
  data_t   wdata;

  modport initiator (
    output valid,
    output write,
    output size,
    output region,
    output wdata
  );

  modport target (
    input valid,
    input write,
    input size,
    input region,
    input wdata
  );

endinterface

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

LOG=sim.log

# Build the testbench together with the bound checker
verilator --binary --timing --assert \
  --top-module tb_ahb_endpoint_slave \
  -f ahb_endpoint_slave.f \
  -o tb_ahb_endpoint_slave

# Let assertion errors through so the testbench prints its summary
./obj_dir/tb_ahb_endpoint_slave +verilator+error+limit+1000 > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Finished with no errors" "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed, see $LOG"
  exit 1
fi

//--- test/ahb_endpoint_slave_checker.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_endpoint_slave_checker (
  input wire tb_clk,
  input wire arst_n_i,
  input wire hresp_i,
  input wire hready_i,
  input wire store_tx_data_i,
  input wire get_rx_data_i
);

  // Count of failed assertions, read back by the testbench summary
  int unsigned fail_count = 0;

  // ERR1 cycle runs straight into ERR2
  err_two_cycle: assert property (@(posedge tb_clk) disable iff (!arst_n_i)
    (hresp_i && !hready_i) |=> (hresp_i && hready_i))
  else begin
    $error("error response lost its second cycle");
    fail_count++;
  end

  // Buffer never pushed and popped in one cycle
  no_push_and_pop: assert property (@(posedge tb_clk) disable iff (!arst_n_i)
    !(store_tx_data_i && get_rx_data_i))
  else begin
    $error("store and get strobes high together");
    fail_count++;
  end

  // Slave ready as soon as reset lifts
  ready_after_reset: assert property (@(posedge tb_clk)
    $rose(arst_n_i) |-> hready_i)
  else begin
    $error("hready low in the first cycle after reset");
    fail_count++;
  end

endmodule

bind ahb_endpoint_slave ahb_endpoint_slave_checker u_checker (
  .tb_clk          (tb_clk),
  .arst_n_i        (arst_n_i),
  .hresp_i         (hresp_o),
  .hready_i        (hready_o),
  .store_tx_data_i (store_tx_data_o),
  .get_rx_data_i   (get_rx_data_o)
);

`default_nettype wire

//--- test/tb_ahb_endpoint_slave.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ahb_endpoint_slave;
  import ahb_pkg::*;
  import endpoint_pkg::*;

  localparam int          CLK_NS         = 4;
  localparam int          RESET_CYCLES   = 10;
  localparam int          NUM_ROWS       = 17;
  localparam int          CYCLES_PER_ROW = 64;
  localparam int          WATCHDOG_NS    =
    (RESET_CYCLES + (NUM_ROWS + 1) * CYCLES_PER_ROW) * CLK_NS;
  localparam int unsigned RAND_SEED      = 32'h2e1d_669e;

  // One table row, a single transfer or a wrap-4 burst
  typedef struct packed {
    logic       write;
    addr_t      addr;
    hsize_t     size;
    logic [2:0] beats;
    logic       rnd;
    data_t      wdata;
    data_t      rx;
    logic [4:0] status;
    occ_t       occ;
    logic       exp_err;
    logic       exp_get;
    data_t      exp_rdata;
    tx_size_t   exp_tx_size;
    logic       exp_reserved;
    logic       exp_store;
  } row_t;

  logic     tb_clk;
  logic     arst_n_i;
  logic     hsel_i;
  addr_t    haddr_i;
  hsize_t   hsize_i;
  htrans_t  htrans_i;
  logic     hwrite_i;
  data_t    hwdata_i;
  data_t    hrdata_o;
  logic     hresp_o;
  logic     hready_o;
  logic     rx_data_ready_i;
  logic     rx_transfer_active_i;
  logic     rx_error_i;
  logic     tx_transfer_active_i;
  logic     tx_error_i;
  occ_t     buffer_occupancy_i;
  data_t    rx_data_i;
  logic     buffer_reserved_o;
  tx_size_t tx_packet_data_size_o;
  logic     get_rx_data_o;
  logic     store_tx_data_o;
  data_t    tx_data_o;
  hsize_t   data_size_o;

  row_t        rows[$];
  string       names[$];
  int          err_count;
  int          tests_run;
  int          tests_failed;

  tb_clock_gen u_clock_gen (
    .clk_o    (tb_clk),
    .arst_n_o (arst_n_i)
  );

  ahb_endpoint_slave u_ahb_endpoint_slave (
    .tb_clk                (tb_clk),
    .arst_n_i              (arst_n_i),
    .hsel_i                (hsel_i),
    .haddr_i               (haddr_i),
    .hsize_i               (hsize_i),
    .htrans_i              (htrans_i),
    .hwrite_i              (hwrite_i),
    .hwdata_i              (hwdata_i),
    .hrdata_o              (hrdata_o),
    .hresp_o               (hresp_o),
    .hready_o              (hready_o),
    .rx_data_ready_i       (rx_data_ready_i),
    .rx_transfer_active_i  (rx_transfer_active_i),
    .rx_error_i            (rx_error_i),
    .tx_transfer_active_i  (tx_transfer_active_i),
    .tx_error_i            (tx_error_i),
    .buffer_occupancy_i    (buffer_occupancy_i),
    .rx_data_i             (rx_data_i),
    .buffer_reserved_o     (buffer_reserved_o),
    .tx_packet_data_size_o (tx_packet_data_size_o),
    .get_rx_data_o         (get_rx_data_o),
    .store_tx_data_o       (store_tx_data_o),
    .tx_data_o             (tx_data_o),
    .data_size_o           (data_size_o)
  );

  // ****************************************
  // Compare tasks
  // ****************************************
  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected 0x%h, actual 0x%h", what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_size(input string what, input tx_size_t exp, input tx_size_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %0d, actual %0d", what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_flag(input string what, input bit exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %b, actual %b", what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_hsize(input string what, input hsize_t exp, input hsize_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %b, actual %b", what, exp, act);
      err_count++;
    end
  endtask

  // Lanes above the access size come out as zero
  function automatic data_t keep_lanes(input hsize_t size);
    if (size == BYTE) begin
      return 32'h0000_00FF;
    end else if (size == HALF) begin
      return 32'h0000_FFFF;
    end
    return 32'hFFFF_FFFF;
  endfunction

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count != errs_before) begin
      tests_failed++;
    end
    $display("[%s] %s", (err_count == errs_before) ? "pass" : "fail", name);
  endtask

  // ****************************************
  // Bus driver
  // ****************************************
  task automatic add_row(input string name, input logic wr, input addr_t addr,
                         input hsize_t size, input logic [2:0] beats, input logic rnd,
                         input data_t wdata, input data_t rx, input logic [4:0] st,
                         input occ_t occ, input logic err, input logic get,
                         input data_t rdata, input tx_size_t txsz, input logic res,
                         input logic store);
    row_t r;
    r = '{wr, addr, size, beats, rnd, wdata, rx, st, occ, err, get, rdata, txsz, res, store};
    rows.push_back(r);
    names.push_back(name);
  endtask

  // Address phase of beat k, with the FWFT head word for it
  task automatic drive_beat(input row_t r, input int k);
    hsel_i    = 1'b1;
    htrans_i  = (k == 0) ? NONSEQ : SEQ;
    // Word beats wrap inside a 16 byte block
    haddr_i   = {r.addr[6:4], r.addr[3:2] + 2'(k), r.addr[1:0]};
    hsize_i   = r.size;
    hwrite_i  = r.write;
    rx_data_i = r.rx + data_t'(k);
  endtask

  task automatic idle_bus();
    hsel_i   = 1'b0;
    htrans_i = IDLE;
    hwrite_i = 1'b0;
  endtask

  task automatic run_row(input int idx);
    row_t  r;
    string nm;
    data_t wd;
    data_t exp_rd;
    int    waits;
    int    k;
    r  = rows[idx];
    nm = names[idx];
    wd = r.rnd ? data_t'($urandom) : r.wdata;
    @(negedge tb_clk);
    {tx_error_i, rx_error_i, tx_transfer_active_i, rx_transfer_active_i,
     rx_data_ready_i} = r.status;
    buffer_occupancy_i = r.occ;
    drive_beat(r, 0);
    for (k = 0; k < int'(r.beats); k++) begin
      // Middle of data phase k, sample first and drive after
      @(negedge tb_clk);
      check_flag({nm, " get_rx_data_o"}, r.exp_get, get_rx_data_o);
      if (r.exp_err) begin
        check_flag({nm, " hready_o ERR1"}, 1'b0, hready_o);
        check_flag({nm, " hresp_o ERR1"}, 1'b1, hresp_o);
        hwdata_i = wd;
        idle_bus();
        waits = 0;
        do begin
          @(negedge tb_clk);
          waits++;
        end while (!hready_o && waits < 16);
        if (!hready_o) begin
          $display("%s: hready_o stayed low after the error response", nm);
          err_count++;
        end
        check_flag({nm, " hresp_o ERR2"}, 1'b1, hresp_o);
        // No strobe in the second error cycle either
        check_flag({nm, " store_tx_data_o ERR2"}, r.exp_store, store_tx_data_o);
        check_flag({nm, " get_rx_data_o ERR2"}, r.exp_get, get_rx_data_o);
      end else begin
        check_flag({nm, " hready_o"}, 1'b1, hready_o);
        check_flag({nm, " hresp_o"}, 1'b0, hresp_o);
        if (!r.write) begin
          exp_rd = r.exp_get ? ((r.rx + data_t'(k)) & keep_lanes(r.size)) : r.exp_rdata;
          check_data({nm, " hrdata_o"}, exp_rd, hrdata_o);
        end
        hwdata_i = wd;
        if (k + 1 < int'(r.beats)) begin
          drive_beat(r, k + 1);
        end else begin
          idle_bus();
        end
      end
    end
    // Cycle after the last data phase
    @(negedge tb_clk);
    check_flag({nm, " store_tx_data_o"}, r.exp_store, store_tx_data_o);
    if (r.exp_store) begin
      check_data({nm, " tx_data_o"}, wd & keep_lanes(r.size), tx_data_o);
      check_hsize({nm, " data_size_o"}, r.size, data_size_o);
    end
    check_size({nm, " tx_packet_data_size_o"}, r.exp_tx_size, tx_packet_data_size_o);
    check_flag({nm, " buffer_reserved_o"}, r.exp_reserved, buffer_reserved_o);
  endtask

  // ****************************************
  // Transaction table
  // ****************************************
  // Columns: name, wr, addr, size, beats, rnd, wdata, rx, status, occ,
  // err, get, rdata, tx size, reserved, store
  task automatic build_table();
    add_row("byte write 0x05", 1'b1, 7'h05, BYTE, 3'd1, 1'b1, 32'h0, 32'h0, 5'h00,
            7'h00, 1'b0, 1'b0, 32'h0, 7'd0, 1'b0, 1'b1);
    add_row("half write 0x12", 1'b1, 7'h12, HALF, 3'd1, 1'b1, 32'h0, 32'h0, 5'h00,
            7'h00, 1'b0, 1'b0, 32'h0, 7'd0, 1'b0, 1'b1);
    add_row("word write 0x3c", 1'b1, 7'h3C, WORD, 3'd1, 1'b1, 32'h0, 32'h0, 5'h00,
            7'h00, 1'b0, 1'b0, 32'h0, 7'd0, 1'b0, 1'b1);
    add_row("wrap4 read 0x3c", 1'b0, 7'h3C, WORD, 3'd4, 1'b0, 32'h0, 32'hC0DE_0000,
            5'h00, 7'h00, 1'b0, 1'b1, 32'h0, 7'd0, 1'b0, 1'b0);
    add_row("byte read 0x21", 1'b0, 7'h21, BYTE, 3'd1, 1'b0, 32'h0, 32'h1234_56A5,
            5'h00, 7'h00, 1'b0, 1'b1, 32'h0, 7'd0, 1'b0, 1'b0);
    add_row("half read 0x02", 1'b0, 7'h02, HALF, 3'd1, 1'b0, 32'h0, 32'h89AB_CDEF,
            5'h00, 7'h00, 1'b0, 1'b1, 32'h0, 7'd0, 1'b0, 1'b0);
    add_row("write 0x46 unallocated", 1'b1, 7'h46, WORD, 3'd1, 1'b1, 32'h0, 32'h0,
            5'h00, 7'h00, 1'b1, 1'b0, 32'h0, 7'd0, 1'b0, 1'b0);
    add_row("write 0x42 read-only", 1'b1, 7'h42, HALF, 3'd1, 1'b1, 32'h0, 32'h0,
            5'h00, 7'h00, 1'b1, 1'b0, 32'h0, 7'd0, 1'b0, 1'b0);
    add_row("read 0x78 unallocated", 1'b0, 7'h78, WORD, 3'd1, 1'b0, 32'h0, 32'h0,
            5'h00, 7'h00, 1'b1, 1'b0, 32'h0, 7'd0, 1'b0, 1'b0);
    add_row("oversized write 0x00", 1'b1, 7'h00, DWORD, 3'd1, 1'b1, 32'h0, 32'h0,
            5'h00, 7'h00, 1'b1, 1'b0, 32'h0, 7'd0, 1'b0, 1'b0);
    add_row("status read a", 1'b0, 7'h40, WORD, 3'd1, 1'b0, 32'h0, 32'h0, 5'b01101,
            7'h00, 1'b0, 1'b0, 32'h0000_0105, 7'd0, 1'b0, 1'b0);
    add_row("status read b", 1'b0, 7'h40, WORD, 3'd1, 1'b0, 32'h0, 32'h0, 5'b10010,
            7'h00, 1'b0, 1'b0, 32'h0000_0202, 7'd0, 1'b0, 1'b0);
    add_row("occupancy read", 1'b0, 7'h44, WORD, 3'd1, 1'b0, 32'h0, 32'h0, 5'h00,
            7'h2A, 1'b0, 1'b0, 32'h0000_002A, 7'd0, 1'b0, 1'b0);
    add_row("tx size write 7", 1'b1, 7'h48, WORD, 3'd1, 1'b0, 32'h7, 32'h0, 5'h00,
            7'h2A, 1'b0, 1'b0, 32'h0, 7'd7, 1'b1, 1'b0);
    // Size survives while tx is active
    add_row("tx active high", 1'b0, 7'h40, WORD, 3'd1, 1'b0, 32'h0, 32'h0, 5'b00100,
            7'h2A, 1'b0, 1'b0, 32'h0000_0004, 7'd7, 1'b1, 1'b0);
    // Falling edge clears size and reservation
    add_row("tx active low", 1'b0, 7'h44, WORD, 3'd1, 1'b0, 32'h0, 32'h0, 5'h00,
            7'h2A, 1'b0, 1'b0, 32'h0000_002A, 7'd0, 1'b0, 1'b0);
    add_row("tx size read", 1'b0, 7'h48, WORD, 3'd1, 1'b0, 32'h0, 32'h0, 5'h00,
            7'h2A, 1'b0, 1'b0, 32'h0, 7'd0, 1'b0, 1'b0);
  endtask

  // ****************************************
  // Sequence and summary
  // ****************************************
  initial begin
    int errs_before;
    int i;
    hsel_i               = 1'b0;
    haddr_i              = '0;
    hsize_i              = BYTE;
    htrans_i             = IDLE;
    hwrite_i             = 1'b0;
    hwdata_i             = '0;
    rx_data_ready_i      = 1'b0;
    rx_transfer_active_i = 1'b0;
    rx_error_i           = 1'b0;
    tx_transfer_active_i = 1'b0;
    tx_error_i           = 1'b0;
    buffer_occupancy_i   = '0;
    rx_data_i            = '0;
    err_count            = 0;
    tests_run            = 0;
    tests_failed         = 0;
    // Seed the generator once
    void'($urandom(RAND_SEED));
    build_table();

    @(posedge arst_n_i);
    @(negedge tb_clk);
    errs_before = err_count;
    check_flag("reset hready_o", 1'b1, hready_o);
    check_flag("reset hresp_o", 1'b0, hresp_o);
    check_flag("reset store_tx_data_o", 1'b0, store_tx_data_o);
    check_flag("reset get_rx_data_o", 1'b0, get_rx_data_o);
    check_flag("reset buffer_reserved_o", 1'b0, buffer_reserved_o);
    check_size("reset tx_packet_data_size_o", 7'd0, tx_packet_data_size_o);
    report_test("reset values", errs_before);

    for (i = 0; i < rows.size(); i++) begin
      errs_before = err_count;
      run_row(i);
      report_test(names[i], errs_before);
    end

    // Fold in failures seen by the bound protocol checker
    if (u_ahb_endpoint_slave.u_checker.fail_count != 0) begin
      $display("Protocol checker flagged %0d assertion failures",
               u_ahb_endpoint_slave.u_checker.fail_count);
      err_count += int'(u_ahb_endpoint_slave.u_checker.fail_count);
    end
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Bound from the table length plus reset
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the test sequence completed");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD_NS = 2;
  localparam int RESET_CYCLES   = 10;

  // Free running 4 ns clock
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Reset low for ten rising edges, released on a falling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire
